//--- compile.f
src/core_pkg.sv
src/isa_pkg.sv
src/regfile.sv
src/alu.sv
src/branch_unit.sv
src/operand_stage.sv
src/ex_stage.sv
src/wb_stage.sv
src/exec_pipe_top.sv
test/exec_pipe_tb.sv

//--- src/alu.sv
`timescale 1ns/1ns

module alu (
    input  isa_pkg::alu_opcode_e           alu_opcode_i,
    input  logic [core_pkg::WORD_SIZE-1:0] alu_src_a_i,
    input  logic [core_pkg::WORD_SIZE-1:0] alu_src_b_i,
    output logic [core_pkg::WORD_SIZE-1:0] alu_res_o
);

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = alu_src_b_i[4:0];
    assign lt_s  = $signed(alu_src_a_i) < $signed(alu_src_b_i);
    assign lt_u  = alu_src_a_i < alu_src_b_i;

    always_comb begin
        case (alu_opcode_i)
            isa_pkg::ALU_SUB: begin
                alu_res_o = alu_src_a_i - alu_src_b_i;
            end
            isa_pkg::ALU_AND: begin
                alu_res_o = alu_src_a_i & alu_src_b_i;
            end
            isa_pkg::ALU_OR: begin
                alu_res_o = alu_src_a_i | alu_src_b_i;
            end
            isa_pkg::ALU_XOR: begin
                alu_res_o = alu_src_a_i ^ alu_src_b_i;
            end
            isa_pkg::ALU_SLL: begin
                alu_res_o = alu_src_a_i << shamt;
            end
            isa_pkg::ALU_SRL: begin
                alu_res_o = alu_src_a_i >> shamt;
            end
            isa_pkg::ALU_SRA: begin
                alu_res_o = $signed(alu_src_a_i) >>> shamt;
            end
            isa_pkg::ALU_SLT: begin
                alu_res_o = core_pkg::WORD_SIZE'(lt_s);
            end
            isa_pkg::ALU_SLTU: begin
                alu_res_o = core_pkg::WORD_SIZE'(lt_u);
            end
            // ADD, and the target sum for branches and jumps
            default: begin
                alu_res_o = alu_src_a_i + alu_src_b_i;
            end
        endcase
    end

endmodule : alu

//--- src/branch_unit.sv
`timescale 1ns/1ns

module branch_unit (
    input  isa_pkg::alu_opcode_e           alu_opcode_i,
    input  logic [core_pkg::WORD_SIZE-1:0] br_src_a_i,
    input  logic [core_pkg::WORD_SIZE-1:0] br_src_b_i,
    output logic                           tkbr_o,
    output logic                           branch_completed_o
);

    logic eq;
    logic lt_s;
    logic lt_u;
    logic cond;

    assign eq   = br_src_a_i == br_src_b_i;
    assign lt_s = $signed(br_src_a_i) < $signed(br_src_b_i);
    assign lt_u = br_src_a_i < br_src_b_i;

    always_comb begin
        case (alu_opcode_i)
            isa_pkg::ALU_BEQ:  cond = eq;
            isa_pkg::ALU_BNE:  cond = !eq;
            isa_pkg::ALU_BLT:  cond = lt_s;
            isa_pkg::ALU_BGE:  cond = !lt_s;
            isa_pkg::ALU_BLTU: cond = lt_u;
            isa_pkg::ALU_BGEU: cond = !lt_u;
            default:           cond = 1'b0;
        endcase
    end

    // Jumps are always taken
    assign tkbr_o = cond || isa_pkg::is_jump(alu_opcode_i);

    assign branch_completed_o = isa_pkg::is_branch(alu_opcode_i)
                             || isa_pkg::is_jump(alu_opcode_i);

endmodule : branch_unit

//--- src/core_pkg.sv
package core_pkg;

    // Data path and PC width
    localparam int WORD_SIZE = 32;

    // Register file geometry
    localparam int REG_SIZE = 5;
    localparam int NUM_REGS = 32;

endpackage : core_pkg

//--- src/ex_stage.sv
`timescale 1ns/1ns

module ex_stage #(
    parameter int ID_WIDTH = 4
) (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  logic                           hazard_i,
    // ID/EX register
    input  logic                           valid_i,
    input  isa_pkg::alu_opcode_e           alu_opcode_i,
    input  logic [core_pkg::WORD_SIZE-1:0] alu_src_a_i,
    input  logic [core_pkg::WORD_SIZE-1:0] alu_src_b_i,
    input  logic [core_pkg::WORD_SIZE-1:0] br_src_a_i,
    input  logic [core_pkg::WORD_SIZE-1:0] br_src_b_i,
    input  logic                           rf_we_i,
    input  logic [core_pkg::REG_SIZE-1:0]  rf_waddr_i,
    input  logic [ID_WIDTH-1:0]            instr_id_i,
    // EX/WB register
    output logic                           valid_o,
    output logic [core_pkg::WORD_SIZE-1:0] alu_res_o,
    output logic                           rf_we_o,
    output logic [core_pkg::REG_SIZE-1:0]  rf_waddr_o,
    output logic                           tkbr_o,
    output logic [core_pkg::WORD_SIZE-1:0] new_pc_o,
    output logic [ID_WIDTH-1:0]            instr_id_o,
    output logic                           flush_o
);

    logic [core_pkg::WORD_SIZE-1:0] alu_res;
    logic                           tkbr;
    logic                           branch_completed;
    logic                           take;
    logic                           valid_q;

    alu alu0 (
        .alu_opcode_i (alu_opcode_i),
        .alu_src_a_i  (alu_src_a_i),
        .alu_src_b_i  (alu_src_b_i),
        .alu_res_o    (alu_res)
    );

    branch_unit branch_unit0 (
        .alu_opcode_i       (alu_opcode_i),
        .br_src_a_i         (br_src_a_i),
        .br_src_b_i         (br_src_b_i),
        .tkbr_o             (tkbr),
        .branch_completed_o (branch_completed)
    );

    // A pending redirect squashes the instruction behind it
    assign take = valid_i && !flush_o;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
            rf_we_o <= 1'b0;
            tkbr_o  <= 1'b0;
        end else if (!hazard_i) begin
            valid_q <= take;
            rf_we_o <= take && rf_we_i;
            tkbr_o  <= take && branch_completed && tkbr;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!hazard_i) begin
            // Jumps write back the link value
            alu_res_o  <= isa_pkg::is_jump(alu_opcode_i) ? br_src_a_i : alu_res;
            new_pc_o   <= alu_res;
            rf_waddr_o <= rf_waddr_i;
            instr_id_o <= instr_id_i;
        end
    end

    // Held entry is hidden from writeback while stalled
    assign valid_o = valid_q && !hazard_i;
    assign flush_o = valid_q && tkbr_o;

endmodule : ex_stage

//--- src/exec_pipe_top.sv
`timescale 1ns/1ns

module exec_pipe_top #(
    parameter int ID_WIDTH = 4
) (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  logic                           hazard_i,
    input  logic                           issue_i,
    input  isa_pkg::alu_opcode_e           op_i,
    input  logic [core_pkg::REG_SIZE-1:0]  rs1_i,
    input  logic [core_pkg::REG_SIZE-1:0]  rs2_i,
    input  logic [core_pkg::REG_SIZE-1:0]  rd_i,
    input  logic                           rd_we_i,
    input  logic                           use_imm_i,
    input  logic [core_pkg::WORD_SIZE-1:0] imm_i,
    input  logic [core_pkg::WORD_SIZE-1:0] pc_i,
    input  logic [ID_WIDTH-1:0]            id_i,
    output logic                           retire_o,
    output logic [ID_WIDTH-1:0]            retire_id_o,
    output logic                           retire_we_o,
    output logic [core_pkg::REG_SIZE-1:0]  retire_rd_o,
    output logic [core_pkg::WORD_SIZE-1:0] retire_data_o,
    output logic                           redirect_o,
    output logic [core_pkg::WORD_SIZE-1:0] redirect_pc_o
);

    // Register file ports
    logic [core_pkg::REG_SIZE-1:0]  rf_raddr_a;
    logic [core_pkg::REG_SIZE-1:0]  rf_raddr_b;
    logic [core_pkg::WORD_SIZE-1:0] rf_rdata_a;
    logic [core_pkg::WORD_SIZE-1:0] rf_rdata_b;
    logic                           rf_we;
    logic [core_pkg::REG_SIZE-1:0]  rf_waddr;
    logic [core_pkg::WORD_SIZE-1:0] rf_wdata;

    // ID/EX
    logic                           id_valid;
    isa_pkg::alu_opcode_e           id_opcode;
    logic [core_pkg::WORD_SIZE-1:0] id_src_a;
    logic [core_pkg::WORD_SIZE-1:0] id_src_b;
    logic [core_pkg::WORD_SIZE-1:0] id_br_a;
    logic [core_pkg::WORD_SIZE-1:0] id_br_b;
    logic                           id_rf_we;
    logic [core_pkg::REG_SIZE-1:0]  id_rf_waddr;
    logic [ID_WIDTH-1:0]            id_instr_id;

    // EX/WB
    logic                           ex_valid;
    logic [core_pkg::WORD_SIZE-1:0] ex_res;
    logic                           ex_rf_we;
    logic [core_pkg::REG_SIZE-1:0]  ex_rf_waddr;
    logic                           ex_tkbr;
    logic [core_pkg::WORD_SIZE-1:0] ex_new_pc;
    logic [ID_WIDTH-1:0]            ex_instr_id;
    logic                           flush;

    regfile regfile0 (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .raddr_a_i (rf_raddr_a),
        .raddr_b_i (rf_raddr_b),
        .rdata_a_o (rf_rdata_a),
        .rdata_b_o (rf_rdata_b),
        .we_i      (rf_we),
        .waddr_i   (rf_waddr),
        .wdata_i   (rf_wdata)
    );

    operand_stage #(.ID_WIDTH(ID_WIDTH)) operand_stage0 (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .hazard_i     (hazard_i),
        .flush_i      (flush),
        .issue_i      (issue_i),
        .op_i         (op_i),
        .rs1_i        (rs1_i),
        .rs2_i        (rs2_i),
        .rd_i         (rd_i),
        .rd_we_i      (rd_we_i),
        .use_imm_i    (use_imm_i),
        .imm_i        (imm_i),
        .pc_i         (pc_i),
        .id_i         (id_i),
        .rf_raddr_a_o (rf_raddr_a),
        .rf_raddr_b_o (rf_raddr_b),
        .rf_rdata_a_i (rf_rdata_a),
        .rf_rdata_b_i (rf_rdata_b),
        .valid_o      (id_valid),
        .alu_opcode_o (id_opcode),
        .alu_src_a_o  (id_src_a),
        .alu_src_b_o  (id_src_b),
        .br_src_a_o   (id_br_a),
        .br_src_b_o   (id_br_b),
        .rf_we_o      (id_rf_we),
        .rf_waddr_o   (id_rf_waddr),
        .instr_id_o   (id_instr_id)
    );

    ex_stage #(.ID_WIDTH(ID_WIDTH)) ex_stage0 (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .hazard_i     (hazard_i),
        .valid_i      (id_valid),
        .alu_opcode_i (id_opcode),
        .alu_src_a_i  (id_src_a),
        .alu_src_b_i  (id_src_b),
        .br_src_a_i   (id_br_a),
        .br_src_b_i   (id_br_b),
        .rf_we_i      (id_rf_we),
        .rf_waddr_i   (id_rf_waddr),
        .instr_id_i   (id_instr_id),
        .valid_o      (ex_valid),
        .alu_res_o    (ex_res),
        .rf_we_o      (ex_rf_we),
        .rf_waddr_o   (ex_rf_waddr),
        .tkbr_o       (ex_tkbr),
        .new_pc_o     (ex_new_pc),
        .instr_id_o   (ex_instr_id),
        .flush_o      (flush)
    );

    wb_stage #(.ID_WIDTH(ID_WIDTH)) wb_stage0 (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .valid_i       (ex_valid),
        .alu_res_i     (ex_res),
        .rf_we_i       (ex_rf_we),
        .rf_waddr_i    (ex_rf_waddr),
        .tkbr_i        (ex_tkbr),
        .new_pc_i      (ex_new_pc),
        .instr_id_i    (ex_instr_id),
        .rf_we_o       (rf_we),
        .rf_waddr_o    (rf_waddr),
        .rf_wdata_o    (rf_wdata),
        .retire_o      (retire_o),
        .retire_id_o   (retire_id_o),
        .retire_we_o   (retire_we_o),
        .retire_rd_o   (retire_rd_o),
        .retire_data_o (retire_data_o),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o)
    );

endmodule : exec_pipe_top

//--- src/isa_pkg.sv
package isa_pkg;

    typedef enum logic [4:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_BEQ,
        ALU_BNE,
        ALU_BLT,
        ALU_BGE,
        ALU_BLTU,
        ALU_BGEU,
        ALU_JAL,
        ALU_JALR
    } alu_opcode_e;

    // Conditional compares
    function automatic logic is_branch(alu_opcode_e op);
        return op inside {ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU};
    endfunction

    // Unconditional control transfers
    function automatic logic is_jump(alu_opcode_e op);
        return op inside {ALU_JAL, ALU_JALR};
    endfunction

endpackage : isa_pkg

//--- src/operand_stage.sv
`timescale 1ns/1ns

module operand_stage #(
    parameter int ID_WIDTH = 4
) (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  logic                           hazard_i,
    input  logic                           flush_i,
    // Decoded instruction
    input  logic                           issue_i,
    input  isa_pkg::alu_opcode_e           op_i,
    input  logic [core_pkg::REG_SIZE-1:0]  rs1_i,
    input  logic [core_pkg::REG_SIZE-1:0]  rs2_i,
    input  logic [core_pkg::REG_SIZE-1:0]  rd_i,
    input  logic                           rd_we_i,
    input  logic                           use_imm_i,
    input  logic [core_pkg::WORD_SIZE-1:0] imm_i,
    input  logic [core_pkg::WORD_SIZE-1:0] pc_i,
    input  logic [ID_WIDTH-1:0]            id_i,
    // Register file read
    output logic [core_pkg::REG_SIZE-1:0]  rf_raddr_a_o,
    output logic [core_pkg::REG_SIZE-1:0]  rf_raddr_b_o,
    input  logic [core_pkg::WORD_SIZE-1:0] rf_rdata_a_i,
    input  logic [core_pkg::WORD_SIZE-1:0] rf_rdata_b_i,
    // ID/EX register
    output logic                           valid_o,
    output isa_pkg::alu_opcode_e           alu_opcode_o,
    output logic [core_pkg::WORD_SIZE-1:0] alu_src_a_o,
    output logic [core_pkg::WORD_SIZE-1:0] alu_src_b_o,
    output logic [core_pkg::WORD_SIZE-1:0] br_src_a_o,
    output logic [core_pkg::WORD_SIZE-1:0] br_src_b_o,
    output logic                           rf_we_o,
    output logic [core_pkg::REG_SIZE-1:0]  rf_waddr_o,
    output logic [ID_WIDTH-1:0]            instr_id_o
);

    logic                           op_branch;
    logic                           op_jump;
    logic                           take;
    logic [core_pkg::WORD_SIZE-1:0] src_a;
    logic [core_pkg::WORD_SIZE-1:0] src_b;
    logic [core_pkg::WORD_SIZE-1:0] br_a;

    assign rf_raddr_a_o = rs1_i;
    assign rf_raddr_b_o = rs2_i;

    assign op_branch = isa_pkg::is_branch(op_i);
    assign op_jump   = isa_pkg::is_jump(op_i);

    // PC relative targets for branches and JAL, JALR stays on rs1
    assign src_a = (op_branch || op_i == isa_pkg::ALU_JAL) ? pc_i : rf_rdata_a_i;
    assign src_b = (use_imm_i || op_branch || op_jump) ? imm_i : rf_rdata_b_i;
    // Link value rides in branch source a
    assign br_a  = op_jump ? pc_i + core_pkg::WORD_SIZE'(4) : rf_rdata_a_i;

    assign take = issue_i && !flush_i;

    // Flush wins over a stall
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
            rf_we_o <= 1'b0;
        end else if (flush_i || !hazard_i) begin
            valid_o <= take;
            rf_we_o <= take && rd_we_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!hazard_i) begin
            alu_opcode_o <= op_i;
            alu_src_a_o  <= src_a;
            alu_src_b_o  <= src_b;
            br_src_a_o   <= br_a;
            br_src_b_o   <= rf_rdata_b_i;
            rf_waddr_o   <= rd_i;
            instr_id_o   <= id_i;
        end
    end

endmodule : operand_stage

//--- src/regfile.sv
`timescale 1ns/1ns

module regfile (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  logic [core_pkg::REG_SIZE-1:0]  raddr_a_i,
    input  logic [core_pkg::REG_SIZE-1:0]  raddr_b_i,
    output logic [core_pkg::WORD_SIZE-1:0] rdata_a_o,
    output logic [core_pkg::WORD_SIZE-1:0] rdata_b_o,
    input  logic                           we_i,
    input  logic [core_pkg::REG_SIZE-1:0]  waddr_i,
    input  logic [core_pkg::WORD_SIZE-1:0] wdata_i
);

    logic [core_pkg::WORD_SIZE-1:0] regs [core_pkg::NUM_REGS];

    // x0 reads zero and a write in flight is bypassed to the reader
    assign rdata_a_o = (raddr_a_i == '0) ? '0 :
                       (we_i && (waddr_i == raddr_a_i)) ? wdata_i : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 :
                       (we_i && (waddr_i == raddr_b_i)) ? wdata_i : regs[raddr_b_i];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < core_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

endmodule : regfile

//--- src/wb_stage.sv
`timescale 1ns/1ns

module wb_stage #(
    parameter int ID_WIDTH = 4
) (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    // EX/WB register
    input  logic                           valid_i,
    input  logic [core_pkg::WORD_SIZE-1:0] alu_res_i,
    input  logic                           rf_we_i,
    input  logic [core_pkg::REG_SIZE-1:0]  rf_waddr_i,
    input  logic                           tkbr_i,
    input  logic [core_pkg::WORD_SIZE-1:0] new_pc_i,
    input  logic [ID_WIDTH-1:0]            instr_id_i,
    // Register file write
    output logic                           rf_we_o,
    output logic [core_pkg::REG_SIZE-1:0]  rf_waddr_o,
    output logic [core_pkg::WORD_SIZE-1:0] rf_wdata_o,
    // Retire and redirect reports
    output logic                           retire_o,
    output logic [ID_WIDTH-1:0]            retire_id_o,
    output logic                           retire_we_o,
    output logic [core_pkg::REG_SIZE-1:0]  retire_rd_o,
    output logic [core_pkg::WORD_SIZE-1:0] retire_data_o,
    output logic                           redirect_o,
    output logic [core_pkg::WORD_SIZE-1:0] redirect_pc_o
);

    // Write lands on the same edge the report is captured
    assign rf_we_o    = valid_i && rf_we_i;
    assign rf_waddr_o = rf_waddr_i;
    assign rf_wdata_o = alu_res_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            retire_o    <= 1'b0;
            retire_we_o <= 1'b0;
            redirect_o  <= 1'b0;
        end else begin
            retire_o    <= valid_i;
            retire_we_o <= valid_i && rf_we_i;
            redirect_o  <= valid_i && tkbr_i;
        end
    end

    always_ff @(posedge clk_i) begin
        retire_id_o   <= instr_id_i;
        retire_rd_o   <= rf_waddr_i;
        retire_data_o <= alu_res_i;
        redirect_pc_o <= new_pc_i;
    end

endmodule : wb_stage

//--- test/exec_patterns.mem
// issue hazard op rs1 rs2 rd rd_we use_imm imm pc id exp(0 none,1 retire,2 redirect) data rpc
// a hazard line keeps the previous instruction fields
1 0 00 00 00 01 1 1 00000007 00000000 1 1 00000007 00000000
1 0 00 00 00 02 1 1 fffffff0 00000000 2 1 fffffff0 00000000
1 0 00 00 00 03 1 1 80000000 00000000 3 1 80000000 00000000
1 0 00 00 00 00 1 1 00000055 00000000 4 1 00000055 00000000
1 0 00 00 00 04 1 1 00000003 00000000 5 1 00000003 00000000
0 0 00 00 00 00 0 0 00000000 00000000 0 0 00000000 00000000
0 0 00 00 00 00 0 0 00000000 00000000 0 0 00000000 00000000
1 0 01 01 02 05 1 0 00000000 00000000 6 1 00000017 00000000
1 0 02 02 00 06 1 1 000000ff 00000000 7 1 000000f0 00000000
1 0 03 01 02 07 1 0 00000000 00000000 8 1 fffffff7 00000000
1 0 04 02 00 08 1 1 0000000f 00000000 9 1 ffffffff 00000000
1 0 05 01 04 09 1 0 00000000 00000000 a 1 00000038 00000000
1 0 06 02 00 0a 1 1 00000004 00000000 b 1 0fffffff 00000000
1 0 07 02 04 0b 1 0 00000000 00000000 c 1 fffffffe 00000000
1 0 08 02 01 0c 1 0 00000000 00000000 d 1 00000001 00000000
1 0 09 02 01 0d 1 0 00000000 00000000 e 1 00000000 00000000
1 0 08 03 00 0e 1 1 00000001 00000000 f 1 00000001 00000000
1 0 00 00 01 0f 1 0 00000000 00000000 0 1 00000007 00000000
0 1 00 00 00 00 0 0 00000000 00000000 0 0 00000000 00000000
1 0 0a 01 01 00 0 0 00000020 00000100 1 2 00000120 00000120
1 0 00 00 00 10 1 1 00000099 00000000 2 0 00000000 00000000
1 0 00 00 00 11 1 1 00000077 00000000 3 0 00000000 00000000
1 0 0b 01 01 00 0 0 00000040 00000200 4 1 00000240 00000000
1 0 0c 02 01 00 0 0 00000010 00000300 5 2 00000310 00000310
0 0 00 00 00 00 0 0 00000000 00000000 0 0 00000000 00000000
0 0 00 00 00 00 0 0 00000000 00000000 0 0 00000000 00000000
1 0 0d 02 01 00 0 0 00000008 00000400 6 1 00000408 00000000
1 0 0e 01 02 00 0 0 fffffffc 00000500 7 2 000004fc 000004fc
0 0 00 00 00 00 0 0 00000000 00000000 0 0 00000000 00000000
0 0 00 00 00 00 0 0 00000000 00000000 0 0 00000000 00000000
1 0 0f 02 01 00 0 0 00000100 00000600 8 2 00000700 00000700
0 0 00 00 00 00 0 0 00000000 00000000 0 0 00000000 00000000
0 0 00 00 00 00 0 0 00000000 00000000 0 0 00000000 00000000
1 0 0a 01 04 00 0 0 00000020 00000180 9 1 000001a0 00000000
1 0 0c 01 02 00 0 0 00000004 000001c0 a 1 000001c4 00000000
1 0 0e 02 01 00 0 0 0000000c 00000240 b 1 0000024c 00000000
1 0 0f 01 02 00 0 0 00000010 00000280 c 1 00000290 00000000
1 0 0b 01 04 00 0 0 00000030 000002c0 d 2 000002f0 000002f0
0 0 00 00 00 00 0 0 00000000 00000000 0 0 00000000 00000000
0 0 00 00 00 00 0 0 00000000 00000000 0 0 00000000 00000000
1 0 0d 01 02 00 0 0 00000020 00000340 e 2 00000360 00000360
0 0 00 00 00 00 0 0 00000000 00000000 0 0 00000000 00000000
0 0 00 00 00 00 0 0 00000000 00000000 0 0 00000000 00000000
1 0 10 00 00 14 1 0 00000100 00000800 f 2 00000804 00000900
1 0 00 00 00 15 1 1 00000099 00000000 0 0 00000000 00000000
1 0 00 00 00 16 1 1 00000077 00000000 1 0 00000000 00000000
1 0 11 01 00 17 1 0 00001000 00000a00 2 2 00000a04 00001007
1 0 01 01 02 15 1 0 00000000 00000000 3 0 00000000 00000000
1 0 00 00 00 16 1 1 00000055 00000000 4 0 00000000 00000000
1 0 00 14 17 18 1 0 00000000 00000000 5 1 00001208 00000000
1 0 00 15 16 19 1 0 00000000 00000000 6 1 00000000 00000000

//--- test/exec_pipe_tb.sv
`timescale 1ns/1ns

module exec_pipe_tb;

    localparam int ID_WIDTH   = 4;
    localparam int FIELDS     = 14;
    localparam int MAX_LINES  = 64;
    localparam int NUM_RANDOM = 24;

    logic                 clk_i;
    logic                 rst_n_i;
    logic                 hazard;
    logic                 issue;
    isa_pkg::alu_opcode_e op;
    logic [4:0]           rs1;
    logic [4:0]           rs2;
    logic [4:0]           rd;
    logic                 rd_we;
    logic                 use_imm;
    logic [31:0]          imm;
    logic [31:0]          pc;
    logic [ID_WIDTH-1:0]  id;

    logic                 retire;
    logic [ID_WIDTH-1:0]  retire_id;
    logic                 retire_we;
    logic [4:0]           retire_rd;
    logic [31:0]          retire_data;
    logic                 redirect;
    logic [31:0]          redirect_pc;

    logic [31:0] pat_mem [0:FIELDS*MAX_LINES-1];
    // Register values the pattern and random streams should have produced
    logic [31:0] shadow [0:31];

    // Expected retirements in issue order
    int                  q_tag[$];
    logic [ID_WIDTH-1:0] q_id[$];
    logic [4:0]          q_rd[$];
    logic                q_we[$];
    logic [31:0]         q_data[$];
    logic                q_redir[$];
    logic [31:0]         q_pc[$];
    int                  q_cyc[$];
    int                  q_stall[$];

    int     cycle = 0;
    int     stall_cnt;
    int     pass_cnt;
    int     fail_cnt;
    int     err_cnt;
    int     line;
    integer seed;

    exec_pipe_top #(.ID_WIDTH(ID_WIDTH)) dut0 (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .hazard_i      (hazard),
        .issue_i       (issue),
        .op_i          (op),
        .rs1_i         (rs1),
        .rs2_i         (rs2),
        .rd_i          (rd),
        .rd_we_i       (rd_we),
        .use_imm_i     (use_imm),
        .imm_i         (imm),
        .pc_i          (pc),
        .id_i          (id),
        .retire_o      (retire),
        .retire_id_o   (retire_id),
        .retire_we_o   (retire_we),
        .retire_rd_o   (retire_rd),
        .retire_data_o (retire_data),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc)
    );

    always #2 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle <= cycle + 1;
    end

    // ALU rules for the random section
    function automatic logic [31:0] alu_model(input int code, input logic [31:0] a,
                                              input logic [31:0] b);
        case (code)
            1: return a - b;
            2: return a & b;
            3: return a | b;
            4: return a ^ b;
            5: return a << b[4:0];
            6: return a >> b[4:0];
            7: return $signed(a) >>> b[4:0];
            8: return {31'b0, $signed(a) < $signed(b)};
            9: return {31'b0, a < b};
            default: return a + b;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input string field,
                                   input logic [31:0] exp, input logic [31:0] act);
        $display("ERROR %s %s: expected %h, actual %h", name, field, exp, act);
        err_cnt++;
    endtask

    task automatic expect_retire(input int tag, input logic [ID_WIDTH-1:0] eid,
                                 input logic [4:0] erd, input logic ewe,
                                 input logic [31:0] edata, input logic eredir,
                                 input logic [31:0] epc);
        q_tag.push_back(tag);
        q_id.push_back(eid);
        q_rd.push_back(erd);
        q_we.push_back(ewe);
        q_data.push_back(edata);
        q_redir.push_back(eredir);
        q_pc.push_back(epc);
        // Sampled on the next edge, reported two edges later
        q_cyc.push_back(cycle + 3);
        q_stall.push_back(stall_cnt);
        if (ewe && erd != 5'd0) begin
            shadow[erd] = edata;
        end
    endtask

    task automatic drive_bubble();
        @(posedge clk_i);
        #1;
        hazard = 1'b0;
        issue  = 1'b0;
    endtask

    task automatic drive_line(input int ln);
        int b;
        b = ln * FIELDS;
        @(posedge clk_i);
        #1;
        if (pat_mem[b+1][0]) begin
            // Stall slot keeps the previous instruction fields
            hazard = 1'b1;
            stall_cnt++;
        end else begin
            hazard  = 1'b0;
            issue   = pat_mem[b][0];
            op      = isa_pkg::alu_opcode_e'(pat_mem[b+2][4:0]);
            rs1     = pat_mem[b+3][4:0];
            rs2     = pat_mem[b+4][4:0];
            rd      = pat_mem[b+5][4:0];
            rd_we   = pat_mem[b+6][0];
            use_imm = pat_mem[b+7][0];
            imm     = pat_mem[b+8];
            pc      = pat_mem[b+9];
            id      = pat_mem[b+10][ID_WIDTH-1:0];
            if (issue && pat_mem[b+11] != 32'd0) begin
                expect_retire(ln, id, rd, rd_we, pat_mem[b+12],
                              pat_mem[b+11] == 32'd2, pat_mem[b+13]);
            end
        end
    endtask

    task automatic issue_random(input int n);
        int          code;
        logic [31:0] b_val;
        logic [31:0] res;
        @(posedge clk_i);
        #1;
        code    = $unsigned($random(seed)) % 10;
        rs1     = $random(seed);
        rs2     = $random(seed);
        rd      = 5'd1 + ($unsigned($random(seed)) % 31);
        use_imm = $random(seed);
        imm     = $random(seed);
        b_val   = use_imm ? imm : shadow[rs2];
        res     = alu_model(code, shadow[rs1], b_val);
        hazard  = 1'b0;
        issue   = 1'b1;
        op      = isa_pkg::alu_opcode_e'(code);
        rd_we   = 1'b1;
        pc      = 32'd0;
        id      = n[ID_WIDTH-1:0];
        expect_retire(1000 + n, id, rd, 1'b1, res, 1'b0, 32'd0);
    endtask

    task automatic wait_drained(input string what);
        int n;
        n = 0;
        while (q_tag.size() != 0 && n < 20) begin
            drive_bubble();
            n++;
        end
        if (q_tag.size() != 0) begin
            $display("Timeout: %s did not retire within 20 cycles", what);
            fail_cnt++;
        end
    endtask

    // Sampled at the falling edge, away from the register updates
    always @(negedge clk_i) begin : retire_check
        int          tag;
        int          bad;
        int          ecyc;
        int          estall;
        logic        eredir;
        logic [31:0] epc;
        string       name;
        if (cycle >= 1 && $isunknown({retire, redirect})) begin
            $display("Retire or redirect output is unknown after reset");
            fail_cnt++;
        end
        if (cycle >= 1 && redirect && !retire) begin
            $display("Redirect was raised without a retiring instruction");
            fail_cnt++;
        end
        if (cycle >= 1 && retire) begin
            if (q_tag.size() == 0) begin
                $display("Retire of id %h was not expected, it should not have retired",
                         retire_id);
                fail_cnt++;
            end else begin
                tag    = q_tag.pop_front();
                eredir = q_redir.pop_front();
                epc    = q_pc.pop_front();
                ecyc   = q_cyc.pop_front();
                estall = q_stall.pop_front();
                bad    = 0;
                if (tag >= 1000) begin
                    name = $sformatf("random %0d", tag - 1000);
                end else begin
                    name = $sformatf("pattern line %0d", tag);
                end
                if (retire_id !== q_id[0]) begin
                    report_mismatch(name, "id", q_id[0], retire_id);
                    bad++;
                end
                if (retire_rd !== q_rd[0]) begin
                    report_mismatch(name, "rd", q_rd[0], retire_rd);
                    bad++;
                end
                if (retire_we !== q_we[0]) begin
                    report_mismatch(name, "write enable", q_we[0], retire_we);
                    bad++;
                end
                if (retire_data !== q_data[0]) begin
                    report_mismatch(name, "data", q_data[0], retire_data);
                    bad++;
                end
                if (redirect !== eredir) begin
                    report_mismatch(name, "redirect", eredir, redirect);
                    bad++;
                end
                if (eredir && redirect_pc !== epc) begin
                    report_mismatch(name, "redirect pc", epc, redirect_pc);
                    bad++;
                end
                // Latency only holds when no stall fell in between
                if (estall == stall_cnt && cycle != ecyc) begin
                    report_mismatch(name, "retire cycle", ecyc, cycle);
                    bad++;
                end
                void'(q_id.pop_front());
                void'(q_rd.pop_front());
                void'(q_we.pop_front());
                void'(q_data.pop_front());
                if (bad == 0) begin
                    pass_cnt++;
                    $display("pass: %s", name);
                end else begin
                    fail_cnt++;
                    $display("fail: %s", name);
                end
            end
        end
    end

    initial begin
        seed      = 32'h833e07f6;
        clk_i     = 1'b0;
        rst_n_i   = 1'b0;
        hazard    = 1'b0;
        issue     = 1'b0;
        op        = isa_pkg::ALU_ADD;
        rs1       = 5'd0;
        rs2       = 5'd0;
        rd        = 5'd0;
        rd_we     = 1'b0;
        use_imm   = 1'b0;
        imm       = 32'd0;
        pc        = 32'd0;
        id        = '0;
        stall_cnt = 0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        err_cnt   = 0;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = 32'd0;
        end
        $readmemh("test/exec_patterns.mem", pat_mem);

        repeat (4) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;

        line = 0;
        while (line < MAX_LINES && !$isunknown(pat_mem[line*FIELDS])) begin
            drive_line(line);
            line++;
        end
        drive_bubble();
        wait_drained("pattern section");

        for (int n = 0; n < NUM_RANDOM; n++) begin
            issue_random(n);
            // Two bubbles put the next read right behind this write
            repeat (2) drive_bubble();
        end
        wait_drained("random section");
        // Room for any stray late retirement
        repeat (3) drive_bubble();

        $display("Tests passed %0d, failed %0d, error lines %0d", pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule : exec_pipe_tb
